// ==== src/vga_fb_pkg.sv ====
package vga_fb_pkg;

  // default bank address width, 2**5 words covers the 8x4 active area
  localparam int ADDR_W = 5;

  // one rgb word, 4 bits per channel
  localparam int DATA_W = 12;

  // per-frame offset of the test pattern
  localparam int PATTERN_STEP = 37;

  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  // single request word, we selects write vs read
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

// ==== src/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank #(
  parameter int ADDR_W = vga_fb_pkg::ADDR_W
) (
  input  logic                          clk,
  input  logic                          rst,
  input  vga_fb_pkg::mem_req_t          req,
  input  logic                          valid,
  output logic                          ready,
  output logic [vga_fb_pkg::DATA_W-1:0] rdata,
  output logic                          rvalid
);

  logic [vga_fb_pkg::DATA_W-1:0] mem [2**ADDR_W];

  // single cycle access, never stalls
  assign ready = 1'b1;

  always_ff @(posedge clk) begin
    if (valid && req.we) begin
      mem[req.addr[ADDR_W-1:0]] <= req.wdata;
    end
    if (valid && !req.we) begin
      rdata <= mem[req.addr[ADDR_W-1:0]];
    end
  end

  // read data shows up the cycle after acceptance
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= valid && !req.we;
    end
  end

endmodule

// ==== src/mem_crossbar.sv ====
`timescale 1ns/1ps

module mem_crossbar #(
  parameter int ADDR_W = vga_fb_pkg::ADDR_W
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          sel,
  input  vga_fb_pkg::mem_req_t          wr_req,
  input  logic                          wr_valid,
  output logic                          wr_ready,
  input  vga_fb_pkg::mem_req_t          rd_req,
  input  logic                          rd_valid,
  output logic                          rd_ready,
  output logic [vga_fb_pkg::DATA_W-1:0] rd_data,
  output logic                          rd_rvalid,
  output vga_fb_pkg::mem_req_t          b0_req,
  output logic                          b0_valid,
  input  logic                          b0_ready,
  input  logic [vga_fb_pkg::DATA_W-1:0] b0_rdata,
  input  logic                          b0_rvalid,
  output vga_fb_pkg::mem_req_t          b1_req,
  output logic                          b1_valid,
  input  logic                          b1_ready,
  input  logic [vga_fb_pkg::DATA_W-1:0] b1_rdata,
  input  logic                          b1_rvalid
);

  // bank that the outstanding read went to
  logic rd_sel_q;

  // banks decode only the low ADDR_W bits
  function automatic vga_fb_pkg::mem_req_t trim(input vga_fb_pkg::mem_req_t r);
    vga_fb_pkg::mem_req_t t;
    t = r;
    t.addr = '0;
    t.addr[ADDR_W-1:0] = r.addr[ADDR_W-1:0];
    return t;
  endfunction

  // sel names the front bank, reader goes there and writer to the other
  assign b0_req   = sel ? trim(wr_req) : trim(rd_req);
  assign b0_valid = sel ? wr_valid : rd_valid;
  assign b1_req   = sel ? trim(rd_req) : trim(wr_req);
  assign b1_valid = sel ? rd_valid : wr_valid;

  assign wr_ready = sel ? b0_ready : b1_ready;
  assign rd_ready = sel ? b1_ready : b0_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_sel_q <= 1'b0;
    end else if (rd_valid && rd_ready) begin
      rd_sel_q <= sel;
    end
  end

  // return path follows the captured sel, so a swap mid-read is safe
  assign rd_data   = rd_sel_q ? b1_rdata : b0_rdata;
  assign rd_rvalid = rd_sel_q ? b1_rvalid : b0_rvalid;

endmodule

// ==== src/buffer_swap_ctrl.sv ====
`timescale 1ns/1ps

module buffer_swap_ctrl (
  input  logic       clk,
  input  logic       rst,
  input  logic       frame_written,
  input  logic       frame_end,
  output logic       front_sel,
  output logic       frame_start,
  output logic [7:0] frame_idx,
  output logic       show
);

  typedef enum logic [1:0] {
    ST_FILL,
    ST_WAIT_DISP,
    ST_SWAP
  } state_t;

  state_t     state;
  logic [7:0] frame_cnt;
  logic       do_swap;

  // frame_written is still high from the last frame while frame_start is out
  always_comb begin
    do_swap = 1'b0;
    case (state)
      ST_FILL:      do_swap = frame_written && !frame_start && (!show || frame_end);
      ST_WAIT_DISP: do_swap = frame_end;
      default:      do_swap = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_SWAP;
      front_sel   <= 1'b0;
      show        <= 1'b0;
      frame_start <= 1'b0;
      frame_idx   <= '0;
      frame_cnt   <= '0;
    end else begin
      frame_start <= 1'b0;
      if (do_swap) begin
        // flip on the frame_end edge so the next slot reads the new front
        front_sel <= ~front_sel;
        show      <= 1'b1;
        state     <= ST_SWAP;
      end else begin
        case (state)
          ST_FILL: begin
            // writer done but display busy, hold until frame boundary
            if (frame_written && !frame_start) begin
              state <= ST_WAIT_DISP;
            end
          end
          ST_SWAP: begin
            frame_start <= 1'b1;
            frame_idx   <= frame_cnt;
            frame_cnt   <= frame_cnt + 8'd1;
            state       <= ST_FILL;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== src/pattern_writer.sv ====
`timescale 1ns/1ps

module pattern_writer #(
  parameter int H_ACTIVE = 8,
  parameter int V_ACTIVE = 4,
  parameter int ADDR_W   = vga_fb_pkg::ADDR_W
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 frame_start,
  input  logic [7:0]           frame_idx,
  output vga_fb_pkg::mem_req_t req,
  input  logic                 ready,
  output logic                 valid,
  output logic                 frame_written
);

  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(H_ACTIVE * V_ACTIVE - 1);

  logic [ADDR_W-1:0]             addr;
  logic [vga_fb_pkg::DATA_W-1:0] word;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid         <= 1'b0;
      frame_written <= 1'b0;
      addr          <= '0;
    end else if (frame_start) begin
      valid         <= 1'b1;
      frame_written <= 1'b0;
      addr          <= '0;
    end else if (valid && ready) begin
      addr <= addr + 1'b1;
      if (addr == LAST_ADDR) begin
        valid         <= 1'b0;
        frame_written <= 1'b1;
      end
    end
  end

  // word tracks addr + step * k, wraps naturally at 12 bits
  always_ff @(posedge clk) begin
    if (frame_start) begin
      word <= vga_fb_pkg::DATA_W'(vga_fb_pkg::PATTERN_STEP * int'(frame_idx));
    end else if (valid && ready) begin
      word <= word + 1'b1;
    end
  end

  always_comb begin
    req                  = '0;
    req.addr[ADDR_W-1:0] = addr;
    req.we               = 1'b1;
    req.wdata            = word;
  end

endmodule

// ==== src/pixel_streamer.sv ====
`timescale 1ns/1ps

module pixel_streamer #(
  parameter int H_ACTIVE = 8,
  parameter int H_TOTAL  = 10,
  parameter int V_ACTIVE = 4,
  parameter int V_TOTAL  = 5,
  parameter int H_SYNC   = 1,
  parameter int ADDR_W   = vga_fb_pkg::ADDR_W
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          show,
  input  logic                          almost_full,
  output vga_fb_pkg::mem_req_t          req,
  output logic                          valid,
  input  logic                          ready,
  input  logic [vga_fb_pkg::DATA_W-1:0] rdata,
  input  logic                          rvalid,
  output logic                          push,
  output vga_fb_pkg::pixel_t            pix,
  output logic                          frame_end
);

  localparam int XW = $clog2(H_TOTAL);
  localparam int YW = $clog2(V_TOTAL);

  logic [XW-1:0]     x;
  logic [YW-1:0]     y;
  logic [ADDR_W-1:0] rd_addr;
  logic              active;
  logic              last_x;
  logic              last_y;
  logic              hold;
  logic              go;
  logic              step;

  // slot issued last cycle, pixel leaves this cycle
  logic pend_valid;
  logic pend_read;
  logic pend_hsync;
  logic pend_vsync;

  assign active = (int'(x) < H_ACTIVE) && (int'(y) < V_ACTIVE);
  assign last_x = (x == XW'(H_TOTAL - 1));
  assign last_y = (y == YW'(V_TOTAL - 1));

  // a held read request stays up regardless of fifo level
  assign go        = hold || (show && !almost_full);
  assign valid     = go && active;
  assign step      = go && (!active || ready);
  assign frame_end = step && last_x && last_y;

  always_ff @(posedge clk) begin
    if (rst) begin
      x          <= '0;
      y          <= '0;
      rd_addr    <= '0;
      hold       <= 1'b0;
      pend_valid <= 1'b0;
    end else begin
      hold       <= valid && !ready;
      pend_valid <= step;
      if (step) begin
        if (last_x) begin
          x <= '0;
          y <= last_y ? '0 : y + 1'b1;
        end else begin
          x <= x + 1'b1;
        end
        if (frame_end) begin
          rd_addr <= '0;
        end else if (active) begin
          rd_addr <= rd_addr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      pend_read  <= active;
      pend_hsync <= int'(x) >= H_TOTAL - H_SYNC;
      pend_vsync <= last_y;
    end
  end

  always_comb begin
    req                  = '0;
    req.addr[ADDR_W-1:0] = rd_addr;
    req.we               = 1'b0;
  end

  // blanking slots go out black
  assign push = pend_valid && (!pend_read || rvalid);

  always_comb begin
    pix.hsync                   = pend_hsync;
    pix.vsync                   = pend_vsync;
    {pix.red, pix.green, pix.blue} = pend_read ? rdata : '0;
  end

endmodule

// ==== src/pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               push,
  input  vga_fb_pkg::pixel_t din,
  output logic               almost_full,
  output vga_fb_pkg::pixel_t pix,
  output logic               pix_valid,
  input  logic               pix_ready
);

  localparam int PW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  vga_fb_pkg::pixel_t mem [FIFO_DEPTH];
  logic [PW-1:0]      wr_ptr;
  logic [PW-1:0]      rd_ptr;
  logic [CW-1:0]      count;
  logic               wr_en;
  logic               rd_en;

  assign wr_en = push && (count != CW'(FIFO_DEPTH));
  assign rd_en = pix_valid && pix_ready;

  assign pix_valid = (count != '0);
  assign pix       = mem[rd_ptr];

  // two spare entries absorb the push already in the streamer pipe
  assign almost_full = (count >= CW'(FIFO_DEPTH - 2));

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(wr_en) - CW'(rd_en);
    end
  end

endmodule

// ==== src/vga_sram_double_buf.sv ====
`timescale 1ns/1ps

module vga_sram_double_buf #(
  parameter int H_ACTIVE   = 8,
  parameter int V_ACTIVE   = 4,
  parameter int H_TOTAL    = 10,
  parameter int V_TOTAL    = 5,
  parameter int H_SYNC     = 1,
  parameter int FIFO_DEPTH = 8,
  parameter int ADDR_W     = vga_fb_pkg::ADDR_W
) (
  input  logic               clk,
  input  logic               rst,
  output vga_fb_pkg::pixel_t pix,
  output logic               pix_valid,
  input  logic               pix_ready
);

  // swap control
  logic       front_sel;
  logic       frame_start;
  logic [7:0] frame_idx;
  logic       frame_written;
  logic       frame_end;
  logic       show;

  // master side of the crossbar
  vga_fb_pkg::mem_req_t          wr_req;
  logic                          wr_valid;
  logic                          wr_ready;
  vga_fb_pkg::mem_req_t          rd_req;
  logic                          rd_valid;
  logic                          rd_ready;
  logic [vga_fb_pkg::DATA_W-1:0] rd_data;
  logic                          rd_rvalid;

  // bank side
  vga_fb_pkg::mem_req_t          b0_req;
  logic                          b0_valid;
  logic                          b0_ready;
  logic [vga_fb_pkg::DATA_W-1:0] b0_rdata;
  logic                          b0_rvalid;
  vga_fb_pkg::mem_req_t          b1_req;
  logic                          b1_valid;
  logic                          b1_ready;
  logic [vga_fb_pkg::DATA_W-1:0] b1_rdata;
  logic                          b1_rvalid;

  // streamer into fifo
  logic               push;
  logic               almost_full;
  vga_fb_pkg::pixel_t st_pix;

  buffer_swap_ctrl u_buffer_swap_ctrl (
    .clk          (clk),
    .rst          (rst),
    .frame_written(frame_written),
    .frame_end    (frame_end),
    .front_sel    (front_sel),
    .frame_start  (frame_start),
    .frame_idx    (frame_idx),
    .show         (show)
  );

  pattern_writer #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE),
    .ADDR_W  (ADDR_W)
  ) u_pattern_writer (
    .clk          (clk),
    .rst          (rst),
    .frame_start  (frame_start),
    .frame_idx    (frame_idx),
    .req          (wr_req),
    .valid        (wr_valid),
    .ready        (wr_ready),
    .frame_written(frame_written)
  );

  pixel_streamer #(
    .H_ACTIVE(H_ACTIVE),
    .H_TOTAL (H_TOTAL),
    .V_ACTIVE(V_ACTIVE),
    .V_TOTAL (V_TOTAL),
    .H_SYNC  (H_SYNC),
    .ADDR_W  (ADDR_W)
  ) u_pixel_streamer (
    .clk        (clk),
    .rst        (rst),
    .show       (show),
    .almost_full(almost_full),
    .req        (rd_req),
    .valid      (rd_valid),
    .ready      (rd_ready),
    .rdata      (rd_data),
    .rvalid     (rd_rvalid),
    .push       (push),
    .pix        (st_pix),
    .frame_end  (frame_end)
  );

  mem_crossbar #(
    .ADDR_W(ADDR_W)
  ) u_mem_crossbar (
    .clk      (clk),
    .rst      (rst),
    .sel      (front_sel),
    .wr_req   (wr_req),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .rd_req   (rd_req),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready),
    .rd_data  (rd_data),
    .rd_rvalid(rd_rvalid),
    .b0_req   (b0_req),
    .b0_valid (b0_valid),
    .b0_ready (b0_ready),
    .b0_rdata (b0_rdata),
    .b0_rvalid(b0_rvalid),
    .b1_req   (b1_req),
    .b1_valid (b1_valid),
    .b1_ready (b1_ready),
    .b1_rdata (b1_rdata),
    .b1_rvalid(b1_rvalid)
  );

  sram_bank #(
    .ADDR_W(ADDR_W)
  ) u_bank0 (
    .clk   (clk),
    .rst   (rst),
    .req   (b0_req),
    .valid (b0_valid),
    .ready (b0_ready),
    .rdata (b0_rdata),
    .rvalid(b0_rvalid)
  );

  sram_bank #(
    .ADDR_W(ADDR_W)
  ) u_bank1 (
    .clk   (clk),
    .rst   (rst),
    .req   (b1_req),
    .valid (b1_valid),
    .ready (b1_ready),
    .rdata (b1_rdata),
    .rvalid(b1_rvalid)
  );

  pixel_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_pixel_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .din        (st_pix),
    .almost_full(almost_full),
    .pix        (pix),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready)
  );

endmodule

// ==== test/pixel_model.svh ====
`ifndef PIXEL_MODEL_SVH
`define PIXEL_MODEL_SVH

// reference model of the display raster and the test pattern
// slot counts from 0 at the first pixel of a frame, x runs fastest

function automatic bit slot_hsync(input int slot_pos);
  int x;
  x = slot_pos % H_TOTAL;
  return x >= H_TOTAL - H_SYNC;
endfunction

function automatic bit slot_vsync(input int slot_pos);
  int y;
  y = slot_pos / H_TOTAL;
  return y == V_TOTAL - 1;
endfunction

function automatic bit slot_active(input int slot_pos);
  int x;
  int y;
  x = slot_pos % H_TOTAL;
  y = slot_pos / H_TOTAL;
  return (x < H_ACTIVE) && (y < V_ACTIVE);
endfunction

function automatic int slot_addr(input int slot_pos);
  return (slot_pos / H_TOTAL) * H_ACTIVE + (slot_pos % H_TOTAL);
endfunction

// rgb word for address a in frame k
function automatic int pattern_word(input int a, input int k);
  return (a + vga_fb_pkg::PATTERN_STEP * k) % 4096;
endfunction

// -1 when no k below 100 fits
function automatic int frame_idx_from(input int a, input int word);
  for (int k = 0; k < 100; k++) begin
    if (pattern_word(a, k) == word) begin
      return k;
    end
  end
  return -1;
endfunction

`endif

// ==== test/tb_vga_sram_double_buf.sv ====
`timescale 1ns/1ps

module tb_vga_sram_double_buf;

  localparam int H_ACTIVE       = 8;
  localparam int V_ACTIVE       = 4;
  localparam int H_TOTAL        = 10;
  localparam int V_TOTAL        = 5;
  localparam int H_SYNC         = 1;
  localparam int FIFO_DEPTH     = 8;
  localparam int NUM_FRAMES     = 12;
  localparam int TIMEOUT_CYCLES = 5000;

  logic               clk;
  logic               rst;
  logic               pix_ready;
  logic               pix_valid;
  vga_fb_pkg::pixel_t pix;

  integer seed = 32'h363b_b8bd;
  int     errors;
  int     cycles;

  // model state
  int slot;
  int cur_k;
  int prev_k;
  int frames_done;
  bit k_known;

  `include "pixel_model.svh"

  vga_sram_double_buf #(
    .H_ACTIVE  (H_ACTIVE),
    .V_ACTIVE  (V_ACTIVE),
    .H_TOTAL   (H_TOTAL),
    .V_TOTAL   (V_TOTAL),
    .H_SYNC    (H_SYNC),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_vga_sram_double_buf (
    .clk      (clk),
    .rst      (rst),
    .pix      (pix),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("** Error %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // one accepted pixel, compared against the slot it should occupy
  task automatic consume_pixel(input vga_fb_pkg::pixel_t p);
    int word;
    word = int'({p.red, p.green, p.blue});
    check_value("hsync", int'(p.hsync), int'(slot_hsync(slot)));
    check_value("vsync", int'(p.vsync), int'(slot_vsync(slot)));
    if (slot_active(slot)) begin
      if (!k_known) begin
        // first active pixel names the frame, order check covers it
        k_known = 1'b1;
        cur_k   = frame_idx_from(slot_addr(slot), word);
        if (cur_k < 0) begin
          $display("no frame index below 100 matches color %0h at slot %0d", word, slot);
          errors++;
        end else if (frames_done == 0) begin
          check_value("first frame k", cur_k, 0);
        end else if (cur_k != prev_k && cur_k != prev_k + 1) begin
          $display("frame order broken, k %0d follows k %0d", cur_k, prev_k);
          errors++;
        end
      end else if (cur_k >= 0) begin
        check_value("color", word, pattern_word(slot_addr(slot), cur_k));
      end
    end else begin
      check_value("blank color", word, 0);
    end
    slot++;
    if (slot == H_TOTAL * V_TOTAL) begin
      slot        = 0;
      frames_done++;
      prev_k      = cur_k;
      k_known     = 1'b0;
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    pix_ready   = 1'b0;
    errors      = 0;
    slot        = 0;
    cur_k       = -1;
    prev_k      = -1;
    frames_done = 0;
    k_known     = 1'b0;

    repeat (4) begin
      @(negedge clk);
      check_value("pix_valid in reset", int'(pix_valid), 0);
    end
    rst = 1'b0;

    // handshake decided here holds through the next rising edge
    cycles = 0;
    while (frames_done < NUM_FRAMES && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      pix_ready = ($unsigned($random(seed)) % 100) < 70;
      if (pix_valid && pix_ready) begin
        consume_pixel(pix);
      end
    end

    if (frames_done < NUM_FRAMES) begin
      $display("timeout, only %0d of %0d frames seen after %0d cycles",
               frames_done, NUM_FRAMES, cycles);
      errors++;
    end
    if (prev_k < 3) begin
      $display("frames did not advance far enough, last k was %0d", prev_k);
      errors++;
    end

    $display("frames %0d, last k %0d, errors %0d", frames_done, prev_k, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+test
src/vga_fb_pkg.sv
src/sram_bank.sv
src/mem_crossbar.sv
src/buffer_swap_ctrl.sv
src/pattern_writer.sv
src/pixel_streamer.sv
src/pixel_fifo.sv
src/vga_sram_double_buf.sv
test/tb_vga_sram_double_buf.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_vga_sram_double_buf \
  --Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
